/* design/mem_island_cfg_pkg.sv */
// Fixed 1 KiB island with 3 narrow ports and 1 wide port over 4 banks and no runtime config
`default_nettype none

package mem_island_cfg_pkg;

    // --------------------------------------
    // Port and bank counts
    // --------------------------------------
    localparam int unsigned NumNarrowPorts = 3;
    localparam int unsigned NumBanks = 4;
    localparam int unsigned NumWideBanks = 2;
    // Narrow banks behind one wide bank
    localparam int unsigned BanksPerWide = NumBanks / NumWideBanks;
    localparam int unsigned WordsPerBank = 64;

    // Data path widths
    localparam int unsigned NarrowDataWidth = 32;
    localparam int unsigned NarrowStrbWidth = NarrowDataWidth / 8;
    localparam int unsigned WideDataWidth = 64;
    localparam int unsigned WideStrbWidth = WideDataWidth / 8;

    // --------------------------------------
    // Address fields
    // --------------------------------------
    //   9       4   3    2   1    0
    //   [ row   ] [ bank   ] [ byte ]
    //              ^ bit 3 alone picks the wide pair
    localparam int unsigned AddrWidth = 10;
    localparam int unsigned BankSelLsb = 2;
    localparam int unsigned BankSelWidth = 2;
    localparam int unsigned WideSelBit = 3;
    localparam int unsigned RowLsb = 4;
    localparam int unsigned RowWidth = 6;

    // Enough bits to number the narrow ports
    localparam int unsigned PortIdxWidth = 2;

    // Plain vectors with a meaning
    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [NarrowDataWidth-1:0] narrow_data_t;
    typedef logic [NarrowStrbWidth-1:0] narrow_strb_t;
    typedef logic [WideDataWidth-1:0] wide_data_t;
    typedef logic [WideStrbWidth-1:0] wide_strb_t;
    // In-bank word index
    typedef logic [RowWidth-1:0] row_t;
    typedef logic [PortIdxWidth-1:0] port_idx_t;

endpackage

`default_nettype wire

/* design/mem_island_bus_pkg.sv */
// Request and response structs carry no ready field and the wide port is never stalled
`default_nettype none

package mem_island_bus_pkg;

    import mem_island_cfg_pkg::*;

    // --------------------------------------
    // Requester side
    // --------------------------------------
    // Narrow request, held by the master until q_ready
    typedef struct packed {
        logic         q_valid;
        addr_t        addr;
        logic         write;
        narrow_data_t wdata;
        narrow_strb_t strb;
    } narrow_req_t;

    // One-cycle response, writes too
    typedef struct packed {
        logic         p_valid;
        narrow_data_t rdata;
    } narrow_rsp_t;

    // Wide request, low three address bits ignored
    typedef struct packed {
        logic       q_valid;
        addr_t      addr;
        logic       write;
        wide_data_t wdata;
        wide_strb_t strb;
    } wide_req_t;

    typedef struct packed {
        logic       p_valid;
        wide_data_t rdata;
    } wide_rsp_t;

    // --------------------------------------
    // Bank side
    // --------------------------------------
    // Tag fields travel with the access and come back with the data
    typedef struct packed {
        logic         en;
        logic         we;
        row_t         row;
        narrow_data_t wdata;
        narrow_strb_t strb;
        logic         is_wide;
        port_idx_t    src;
    } bank_req_t;

    typedef struct packed {
        logic         valid;
        logic         is_wide;
        port_idx_t    src;
        narrow_data_t rdata;
    } bank_rsp_t;

endpackage

`default_nettype wire

/* design/mem_request_router.sv */
// Wide port always wins its bank pair and can starve narrow ports since there is no fairness
`timescale 1ns/100ps
`default_nettype none

module mem_request_router
    import mem_island_cfg_pkg::*;
    import mem_island_bus_pkg::*;
(
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  narrow_req_t [NumNarrowPorts-1:0] narrow_req_i,
    input  wide_req_t                        wide_req_i,
    output logic [NumNarrowPorts-1:0]        narrow_ready_o,
    output bank_req_t [NumBanks-1:0]         bank_req_o
);

    // Port index wrap for the round-robin search
    function automatic port_idx_t wrap_port(int unsigned idx);
        return port_idx_t'(idx % NumNarrowPorts);
    endfunction

    // Decoded fields per narrow port
    logic [BankSelWidth-1:0] narrow_bank [NumNarrowPorts];
    row_t                    narrow_row  [NumNarrowPorts];

    // Decoded wide fields
    row_t                    wide_row;
    logic                    wide_sel;
    logic [NumBanks-1:0]     wide_hit;

    // Round-robin state, one pointer per bank
    port_idx_t               rr_ptr_q [NumBanks];

    // Per-bank narrow grant
    logic [NumBanks-1:0]     narrow_gnt;
    port_idx_t               gnt_port [NumBanks];

    // --------------------------------------
    // Address decode
    // --------------------------------------
    always_comb begin
        for (int p = 0; p < NumNarrowPorts; p++) begin
            narrow_bank[p] = narrow_req_i[p].addr[BankSelLsb +: BankSelWidth];
            narrow_row[p]  = narrow_req_i[p].addr[RowLsb +: RowWidth];
        end
        wide_row = wide_req_i.addr[RowLsb +: RowWidth];
        wide_sel = wide_req_i.addr[WideSelBit];
        // Both banks of the selected pair are taken by the wide access
        for (int b = 0; b < NumBanks; b++) begin
            wide_hit[b] = wide_req_i.q_valid && (wide_sel == 1'(b / BanksPerWide));
        end
    end

    // --------------------------------------
    // Round-robin arbitration
    // --------------------------------------
    always_comb begin
        port_idx_t cand;
        cand = '0;
        for (int b = 0; b < NumBanks; b++) begin
            narrow_gnt[b] = 1'b0;
            gnt_port[b]   = '0;
            // Search upward from the pointer
            for (int k = 0; k < NumNarrowPorts; k++) begin
                cand = wrap_port(int'(rr_ptr_q[b]) + k);
                if (!wide_hit[b] && !narrow_gnt[b] &&
                        narrow_req_i[cand].q_valid &&
                        narrow_bank[cand] == BankSelWidth'(b)) begin
                    narrow_gnt[b] = 1'b1;
                    gnt_port[b]   = cand;
                end
            end
        end
    end

    // A port aims at one bank only, so at most one grant per port
    always_comb begin
        narrow_ready_o = '0;
        for (int b = 0; b < NumBanks; b++) begin
            if (narrow_gnt[b]) begin
                narrow_ready_o[gnt_port[b]] = 1'b1;
            end
        end
    end

    // --------------------------------------
    // Bank request drive
    // --------------------------------------
    always_comb begin
        int unsigned half;
        half = 0;
        for (int b = 0; b < NumBanks; b++) begin
            // Lane of this bank inside a wide word
            half = b % BanksPerWide;
            bank_req_o[b] = '0;
            if (wide_hit[b]) begin
                bank_req_o[b].en      = 1'b1;
                bank_req_o[b].we      = wide_req_i.write;
                bank_req_o[b].row     = wide_row;
                bank_req_o[b].wdata   = wide_req_i.wdata[half*NarrowDataWidth +: NarrowDataWidth];
                bank_req_o[b].strb    = wide_req_i.strb[half*NarrowStrbWidth +: NarrowStrbWidth];
                bank_req_o[b].is_wide = 1'b1;
                bank_req_o[b].src     = '0;
            end else if (narrow_gnt[b]) begin
                bank_req_o[b].en      = 1'b1;
                bank_req_o[b].we      = narrow_req_i[gnt_port[b]].write;
                bank_req_o[b].row     = narrow_row[gnt_port[b]];
                bank_req_o[b].wdata   = narrow_req_i[gnt_port[b]].wdata;
                bank_req_o[b].strb    = narrow_req_i[gnt_port[b]].strb;
                bank_req_o[b].is_wide = 1'b0;
                // Return route for the merger
                bank_req_o[b].src     = gnt_port[b];
            end
        end
    end

    // Pointer moves past the winner, wide grants leave it alone
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int b = 0; b < NumBanks; b++) begin
                rr_ptr_q[b] <= '0;
            end
        end else begin
            for (int b = 0; b < NumBanks; b++) begin
                if (narrow_gnt[b]) begin
                    rr_ptr_q[b] <= wrap_port(int'(gnt_port[b]) + 1);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/mem_bank.sv */
// Storage is not cleared by reset and read data after a write is undefined
`timescale 1ns/100ps
`default_nettype none

module mem_bank
    import mem_island_cfg_pkg::*;
    import mem_island_bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  bank_req_t bank_req_i,
    output bank_rsp_t bank_rsp_o
);

    // Word storage
    narrow_data_t mem_q [WordsPerBank];

    // Response pipeline stage
    narrow_data_t rdata_q;
    logic         valid_q;
    logic         is_wide_q;
    port_idx_t    src_q;

    // --------------------------------------
    // Byte-strobed write
    // --------------------------------------
    always_ff @(posedge clk_i) begin
        if (bank_req_i.en && bank_req_i.we) begin
            for (int i = 0; i < NarrowStrbWidth; i++) begin
                if (bank_req_i.strb[i]) begin
                    mem_q[bank_req_i.row][8*i +: 8] <= bank_req_i.wdata[8*i +: 8];
                end
            end
        end
    end

    // Registered read and return tags
    always_ff @(posedge clk_i) begin
        if (bank_req_i.en) begin
            if (!bank_req_i.we) begin
                rdata_q <= mem_q[bank_req_i.row];
            end
            is_wide_q <= bank_req_i.is_wide;
            src_q     <= bank_req_i.src;
        end
    end

    // Response valid one cycle after enable
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= bank_req_i.en;
        end
    end

    // --------------------------------------
    // Response out
    // --------------------------------------
    always_comb begin
        bank_rsp_o.valid   = valid_q;
        bank_rsp_o.is_wide = is_wide_q;
        bank_rsp_o.src     = src_q;
        bank_rsp_o.rdata   = rdata_q;
    end

endmodule

`default_nettype wire

/* design/mem_response_merger.sv */
// Purely combinational and relies on the router never granting one port two banks at once
`timescale 1ns/100ps
`default_nettype none

module mem_response_merger
    import mem_island_cfg_pkg::*;
    import mem_island_bus_pkg::*;
(
    input  bank_rsp_t [NumBanks-1:0]         bank_rsp_i,
    output narrow_rsp_t [NumNarrowPorts-1:0] narrow_rsp_o,
    output wide_rsp_t                        wide_rsp_o
);

    // --------------------------------------
    // Narrow return path
    // --------------------------------------
    always_comb begin
        for (int p = 0; p < NumNarrowPorts; p++) begin
            narrow_rsp_o[p] = '0;
            // At most one bank carries this port's tag
            for (int b = 0; b < NumBanks; b++) begin
                if (bank_rsp_i[b].valid && !bank_rsp_i[b].is_wide &&
                        bank_rsp_i[b].src == port_idx_t'(p)) begin
                    narrow_rsp_o[p].p_valid = 1'b1;
                    narrow_rsp_o[p].rdata   = bank_rsp_i[b].rdata;
                end
            end
        end
    end

    // --------------------------------------
    // Wide return path
    // --------------------------------------
    always_comb begin
        int unsigned lo;
        int unsigned hi;
        lo = 0;
        hi = 0;
        wide_rsp_o = '0;
        for (int w = 0; w < NumWideBanks; w++) begin
            // Bank pair of this wide bank
            lo = w * BanksPerWide;
            hi = lo + 1;
            // Both halves were issued on the same edge
            if (bank_rsp_i[lo].valid && bank_rsp_i[lo].is_wide &&
                    bank_rsp_i[hi].valid && bank_rsp_i[hi].is_wide) begin
                wide_rsp_o.p_valid = 1'b1;
                // Low bank fills the low half
                wide_rsp_o.rdata   = {bank_rsp_i[hi].rdata, bank_rsp_i[lo].rdata};
            end
        end
    end

endmodule

`default_nettype wire

/* design/mem_island_top.sv */
// Fixed one-cycle latency with no response back-pressure and only narrow ports can stall
`timescale 1ns/100ps
`default_nettype none

module mem_island_top
    import mem_island_cfg_pkg::*;
    import mem_island_bus_pkg::*;
(
    input  logic                             clk_i,
    input  logic                             rst_n_i,

    // Narrow requesters
    input  narrow_req_t [NumNarrowPorts-1:0] narrow_req_i,
    output logic [NumNarrowPorts-1:0]        narrow_ready_o,
    output narrow_rsp_t [NumNarrowPorts-1:0] narrow_rsp_o,

    // Wide requester, always accepted
    input  wide_req_t                        wide_req_i,
    output wide_rsp_t                        wide_rsp_o
);

    // Routed accesses and tagged responses
    bank_req_t [NumBanks-1:0] bank_req;
    bank_rsp_t [NumBanks-1:0] bank_rsp;

    // --------------------------------------
    // Arbitration and routing
    // --------------------------------------
    mem_request_router u_router (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .narrow_req_i   (narrow_req_i),
        .wide_req_i     (wide_req_i),
        .narrow_ready_o (narrow_ready_o),
        .bank_req_o     (bank_req)
    );

    // --------------------------------------
    // Banks
    // --------------------------------------
    for (genvar g = 0; g < NumBanks; g++) begin : g_bank
        mem_bank u_bank (
            .clk_i      (clk_i),
            .rst_n_i    (rst_n_i),
            .bank_req_i (bank_req[g]),
            .bank_rsp_o (bank_rsp[g])
        );
    end

    // Responses back to the ports
    mem_response_merger u_merger (
        .bank_rsp_i   (bank_rsp),
        .narrow_rsp_o (narrow_rsp_o),
        .wide_rsp_o   (wide_rsp_o)
    );

endmodule

`default_nettype wire

/* testbench/mem_island_assert.sv */
// Checks handshakes at the top-level ports only and never looks at data values
`timescale 1ns/100ps
`default_nettype none

module mem_island_assert
    import mem_island_cfg_pkg::*;
    import mem_island_bus_pkg::*;
(
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  narrow_req_t [NumNarrowPorts-1:0] narrow_req_i,
    input  logic [NumNarrowPorts-1:0]        narrow_ready_o,
    input  narrow_rsp_t [NumNarrowPorts-1:0] narrow_rsp_o,
    input  wide_req_t                        wide_req_i,
    input  wide_rsp_t                        wide_rsp_o
);

    int unsigned assert_fails = 0;

    // Narrow accept per port
    logic [NumNarrowPorts-1:0] accept;

    always_comb begin
        for (int p = 0; p < NumNarrowPorts; p++) begin
            accept[p] = narrow_req_i[p].q_valid && narrow_ready_o[p];
        end
    end

    // --------------------------------------
    // Narrow ports
    // --------------------------------------
    for (genvar p = 0; p < NumNarrowPorts; p++) begin : g_port
        // Response exactly one edge after the accept
        rsp_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                accept[p] |=> narrow_rsp_o[p].p_valid)
            else begin
                assert_fails++;
                $error("narrow port %0d accepted without a response next cycle", p);
            end

        rsp_needs_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                narrow_rsp_o[p].p_valid |-> $past(accept[p]))
            else begin
                assert_fails++;
                $error("narrow port %0d responded without an accept", p);
            end

        ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                narrow_ready_o[p] |-> narrow_req_i[p].q_valid)
            else begin
                assert_fails++;
                $error("narrow port %0d ready without a request", p);
            end
    end

    // Wide port is never stalled
    wide_rsp_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            wide_rsp_o.p_valid |-> $past(wide_req_i.q_valid))
        else begin
            assert_fails++;
            $error("wide port responded without a request");
        end

endmodule

bind mem_island_top mem_island_assert u_assert (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .narrow_req_i   (narrow_req_i),
    .narrow_ready_o (narrow_ready_o),
    .narrow_rsp_o   (narrow_rsp_o),
    .wide_req_i     (wide_req_i),
    .wide_rsp_o     (wide_rsp_o)
);

`default_nettype wire

/* testbench/tb_mem_island.sv */
// Fills the whole memory through the wide port before any read check and runs a 100 ns clock
`timescale 1ns/100ps
`default_nettype none

module tb_mem_island
    import mem_island_cfg_pkg::*;
    import mem_island_bus_pkg::*;
();

    localparam int ClkPeriod = 100;
    localparam int unsigned Seed = 32'h9ebb_d70a;
    localparam int FillCycles = (2**AddrWidth) / 8;
    localparam int RandomCycles = 300;
    // Cycle budget per test, in run order
    localparam int TestCycles = 5 + FillCycles + 24 + 12 + 30 + 10 + RandomCycles + 10;
    localparam int WatchdogCycles = TestCycles + 100;

    logic clk = 1'b0;
    logic rst_n;
    narrow_req_t [NumNarrowPorts-1:0] narrow_req;
    logic [NumNarrowPorts-1:0]        narrow_ready;
    narrow_rsp_t [NumNarrowPorts-1:0] narrow_rsp;
    wide_req_t                        wide_req;
    wide_rsp_t                        wide_rsp;

    // Reference byte image and arbiter state
    logic [7:0] ref_mem [2**AddrWidth];
    port_idx_t  rr_ptr [NumBanks];
    logic [NumNarrowPorts-1:0] accepted;
    int unsigned ctrl_errs = 0;
    int unsigned data_errs = 0;

    mem_island_top DUT (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .narrow_req_i   (narrow_req),
        .narrow_ready_o (narrow_ready),
        .narrow_rsp_o   (narrow_rsp),
        .wide_req_i     (wide_req),
        .wide_rsp_o     (wide_rsp)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // --------------------------------------
    // Reference model
    // --------------------------------------
    function automatic logic [63:0] model_read(addr_t a, int nbytes);
        logic [63:0] d;
        int base;
        d = '0;
        base = int'(a) & ~(nbytes - 1);
        for (int i = 0; i < nbytes; i++) begin
            d[8*i +: 8] = ref_mem[base + i];
        end
        return d;
    endfunction

    task automatic model_write(addr_t a, int nbytes, logic [63:0] data, logic [7:0] strb);
        int base;
        base = int'(a) & ~(nbytes - 1);
        for (int i = 0; i < nbytes; i++) begin
            if (strb[i]) begin
                ref_mem[base + i] = data[8*i +: 8];
            end
        end
    endtask

    task automatic compare_value(string name, logic [63:0] exp, logic [63:0] got, bit is_data);
        assert (got === exp) else begin
            if (is_data) begin
                data_errs++;
            end else begin
                ctrl_errs++;
            end
            $display("ERROR %0t %s expected %h observed %h", $time, name, exp, got);
        end
    endtask

    // --------------------------------------
    // Request builders
    // --------------------------------------
    function automatic addr_t narrow_addr(int row, int bank);
        return addr_t'((row << RowLsb) | (bank << BankSelLsb));
    endfunction

    // Low three bits are random, the island ignores them
    function automatic addr_t wide_addr(int row, int pair);
        return addr_t'((row << RowLsb) | (pair << WideSelBit) | int'($urandom_range(7)));
    endfunction

    function automatic narrow_req_t make_narrow(logic wr, addr_t a, narrow_data_t d,
                                                narrow_strb_t s);
        narrow_req_t r;
        r.q_valid = 1'b1;
        r.addr    = a;
        r.write   = wr;
        r.wdata   = d;
        r.strb    = s;
        return r;
    endfunction

    function automatic wide_req_t make_wide(logic wr, addr_t a, wide_data_t d, wide_strb_t s);
        wide_req_t r;
        r.q_valid = 1'b1;
        r.addr    = a;
        r.write   = wr;
        r.wdata   = d;
        r.strb    = s;
        return r;
    endfunction

    function automatic narrow_req_t random_narrow(int bank);
        return make_narrow(1'($urandom_range(1)),
                           narrow_addr(int'($urandom_range(WordsPerBank - 1)), bank),
                           $urandom, 4'($urandom));
    endfunction

    function automatic wide_req_t random_wide(int pair);
        return make_wide(1'($urandom_range(1)),
                         wide_addr(int'($urandom_range(WordsPerBank - 1)), pair),
                         {$urandom, $urandom}, 8'($urandom));
    endfunction

    function automatic bit narrow_pending();
        bit any;
        any = 1'b0;
        for (int p = 0; p < NumNarrowPorts; p++) begin
            any = any | narrow_req[p].q_valid;
        end
        return any;
    endfunction

    task automatic idle_all();
        narrow_req = '0;
        wide_req   = '0;
    endtask

    // Granted ports drop their request, stalled ones keep it unchanged
    task automatic release_accepted();
        for (int p = 0; p < NumNarrowPorts; p++) begin
            if (accepted[p]) begin
                narrow_req[p] = '0;
            end
        end
    endtask

    // --------------------------------------
    // One clock cycle with prediction
    // --------------------------------------
    // Entered just after the drive, returns one edge later
    task automatic clock_cycle();
        logic [NumNarrowPorts-1:0] exp_ready;
        logic [NumNarrowPorts-1:0] exp_nread;
        narrow_data_t exp_ndata [NumNarrowPorts];
        logic exp_wvalid;
        logic exp_wread;
        wide_data_t exp_wdata;
        port_idx_t cand;
        logic taken;
        #1;
        exp_ready = '0;
        // Wide pair wins, otherwise first valid port upward from the pointer
        for (int b = 0; b < NumBanks; b++) begin
            taken = wide_req.q_valid &&
                    (int'(wide_req.addr[WideSelBit]) == b / int'(BanksPerWide));
            for (int k = 0; k < NumNarrowPorts; k++) begin
                cand = port_idx_t'((int'(rr_ptr[b]) + k) % int'(NumNarrowPorts));
                if (!taken && narrow_req[cand].q_valid &&
                        int'(narrow_req[cand].addr[BankSelLsb +: BankSelWidth]) == b) begin
                    taken = 1'b1;
                    exp_ready[cand] = 1'b1;
                    rr_ptr[b] = port_idx_t'((int'(cand) + 1) % int'(NumNarrowPorts));
                end
            end
        end
        compare_value("narrow_ready_o", 64'(exp_ready), 64'(narrow_ready), 1'b0);
        accepted = exp_ready;
        // Reads see memory as it was before this edge
        for (int p = 0; p < NumNarrowPorts; p++) begin
            exp_nread[p] = exp_ready[p] && !narrow_req[p].write;
            exp_ndata[p] = narrow_data_t'(model_read(narrow_req[p].addr, 4));
        end
        exp_wvalid = wide_req.q_valid;
        exp_wread  = wide_req.q_valid && !wide_req.write;
        exp_wdata  = model_read(wide_req.addr, 8);
        for (int p = 0; p < NumNarrowPorts; p++) begin
            if (exp_ready[p] && narrow_req[p].write) begin
                model_write(narrow_req[p].addr, 4, 64'(narrow_req[p].wdata),
                            8'(narrow_req[p].strb));
            end
        end
        if (wide_req.q_valid && wide_req.write) begin
            model_write(wide_req.addr, 8, wide_req.wdata, wide_req.strb);
        end
        @(posedge clk);
        #1;
        for (int p = 0; p < NumNarrowPorts; p++) begin
            compare_value($sformatf("narrow_rsp_o[%0d].p_valid", p), 64'(exp_ready[p]),
                          64'(narrow_rsp[p].p_valid), 1'b0);
            if (exp_nread[p]) begin
                compare_value($sformatf("narrow_rsp_o[%0d].rdata", p), 64'(exp_ndata[p]),
                              64'(narrow_rsp[p].rdata), 1'b1);
            end
        end
        compare_value("wide_rsp_o.p_valid", 64'(exp_wvalid), 64'(wide_rsp.p_valid), 1'b0);
        if (exp_wread) begin
            compare_value("wide_rsp_o.rdata", exp_wdata, wide_rsp.rdata, 1'b1);
        end
    endtask

    task automatic drain_narrow();
        while (narrow_pending()) begin
            clock_cycle();
            release_accepted();
        end
    endtask

    // --------------------------------------
    // Directed tests
    // --------------------------------------
    task automatic check_quiet();
        compare_value("narrow_ready_o", 64'(0), 64'(narrow_ready), 1'b0);
        for (int p = 0; p < NumNarrowPorts; p++) begin
            compare_value($sformatf("narrow_rsp_o[%0d].p_valid", p), 64'(0),
                          64'(narrow_rsp[p].p_valid), 1'b0);
        end
        compare_value("wide_rsp_o.p_valid", 64'(0), 64'(wide_rsp.p_valid), 1'b0);
    endtask

    task automatic reset_test();
        rst_n = 1'b0;
        idle_all();
        // Wide read enables two banks while their response valids are held in reset
        wide_req = make_wide(1'b0, '0, '0, '0);
        accepted = '0;
        for (int b = 0; b < NumBanks; b++) begin
            rr_ptr[b] = '0;
        end
        repeat (4) begin
            @(posedge clk);
            #1;
            check_quiet();
        end
        rst_n = 1'b1;
        idle_all();
        // First cycle out of reset stays quiet
        clock_cycle();
    endtask

    // Byte value mixes all ten address bits
    task automatic fill_memory();
        wide_data_t d;
        addr_t a;
        for (int w = 0; w < FillCycles; w++) begin
            for (int i = 0; i < 8; i++) begin
                a = addr_t'(w * 8 + i);
                d[8*i +: 8] = a[7:0] ^ {4{a[9:8]}};
            end
            wide_req = make_wide(1'b1, addr_t'(w * 8), d, 8'hff);
            clock_cycle();
        end
        idle_all();
    endtask

    task automatic narrow_strobe_test();
        int row;
        for (int p = 0; p < NumNarrowPorts; p++) begin
            for (int b = 0; b < NumBanks; b++) begin
                row = int'($urandom_range(WordsPerBank - 1));
                narrow_req[p] = make_narrow(1'b1, narrow_addr(row, b), $urandom, 4'($urandom));
                clock_cycle();
                narrow_req[p] = make_narrow(1'b0, narrow_addr(row, b), '0, '0);
                clock_cycle();
                narrow_req[p] = '0;
            end
        end
    endtask

    task automatic wide_split_test();
        int row;
        int lo;
        for (int w = 0; w < NumWideBanks; w++) begin
            row = int'($urandom_range(WordsPerBank - 1));
            lo  = w * int'(BanksPerWide);
            wide_req = make_wide(1'b1, wide_addr(row, w), {$urandom, $urandom}, 8'hff);
            clock_cycle();
            // Both halves read back in one cycle
            wide_req = '0;
            narrow_req[0] = make_narrow(1'b0, narrow_addr(row, lo), '0, '0);
            narrow_req[1] = make_narrow(1'b0, narrow_addr(row, lo + 1), '0, '0);
            clock_cycle();
            narrow_req[0] = make_narrow(1'b1, narrow_addr(row, lo), $urandom, 4'($urandom));
            narrow_req[1] = '0;
            narrow_req[2] = make_narrow(1'b1, narrow_addr(row, lo + 1), $urandom, 4'($urandom));
            clock_cycle();
            idle_all();
            wide_req = make_wide(1'b0, wide_addr(row, w), '0, '0);
            clock_cycle();
            // Partial wide strobes
            wide_req = make_wide(1'b1, wide_addr(row, w), {$urandom, $urandom}, 8'($urandom));
            clock_cycle();
            wide_req = make_wide(1'b0, wide_addr(row, w), '0, '0);
            clock_cycle();
            idle_all();
        end
    endtask

    task automatic contention_test();
        for (int b = 0; b < NumBanks; b++) begin
            repeat (2) begin
                for (int p = 0; p < NumNarrowPorts; p++) begin
                    narrow_req[p] = random_narrow(b);
                end
                drain_narrow();
            end
        end
        // One bank per port, all granted together
        for (int p = 0; p < NumNarrowPorts; p++) begin
            narrow_req[p] = random_narrow(p);
        end
        drain_narrow();
    endtask

    task automatic wide_priority_test();
        int lo;
        for (int w = 0; w < NumWideBanks; w++) begin
            lo = w * int'(BanksPerWide);
            narrow_req[0] = random_narrow(lo);
            narrow_req[1] = random_narrow(lo + 1);
            narrow_req[2] = random_narrow((1 - w) * int'(BanksPerWide));
            repeat (2) begin
                wide_req = random_wide(w);
                clock_cycle();
                release_accepted();
            end
            wide_req = '0;
            drain_narrow();
        end
    endtask

    task automatic random_traffic_test();
        for (int c = 0; c < RandomCycles; c++) begin
            for (int p = 0; p < NumNarrowPorts; p++) begin
                if (!narrow_req[p].q_valid && $urandom_range(3) != 0) begin
                    narrow_req[p] = random_narrow(int'($urandom_range(NumBanks - 1)));
                end
            end
            if ($urandom_range(3) == 0) begin
                wide_req = random_wide(int'($urandom_range(1)));
            end else begin
                wide_req = '0;
            end
            clock_cycle();
            release_accepted();
        end
        wide_req = '0;
        drain_narrow();
    endtask

    // --------------------------------------
    // Run control
    // --------------------------------------
    initial begin
        void'($urandom(Seed));
        reset_test();
        fill_memory();
        narrow_strobe_test();
        wide_split_test();
        contention_test();
        wide_priority_test();
        random_traffic_test();
        $display("Errors: %0d control, %0d data, %0d assertion", ctrl_errs, data_errs,
                 DUT.u_assert.assert_fails);
        if (ctrl_errs == 0 && data_errs == 0 && DUT.u_assert.assert_fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("Watchdog expired before all tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
design/mem_island_cfg_pkg.sv
design/mem_island_bus_pkg.sv
design/mem_request_router.sv
design/mem_bank.sv
design/mem_response_merger.sv
design/mem_island_top.sv
testbench/mem_island_assert.sv
testbench/tb_mem_island.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the memory island testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_mem_island -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    echo "Simulation passed, see $LOG"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
